//--- hw/bus_pkg.sv
// bus beat struct, phase encoding and agent ids
// line and beat geometry of the shared memory bus
`default_nettype none

package bus_pkg;

   // a line moves as four 32-bit beats
   localparam int LINE_BYTES = 16;
   localparam int BEAT_BYTES = 4;
   localparam int BEATS      = LINE_BYTES / BEAT_BYTES;
   localparam int LINE_BITS  = LINE_BYTES * 8;
   localparam int BEAT_BITS  = BEAT_BYTES * 8;
   localparam int SIZE_W     = $clog2(LINE_BYTES) + 1;  // holds 16 down to 0
   localparam int BEAT_IDX_W = $clog2(BEATS);
   localparam int BEAT_SHIFT = $clog2(BEAT_BYTES);    // byte count to lane index
   localparam int ADDR_W     = 16;

   // ram depth in lines, indexed by addr[9:4]
   localparam int MEM_LINES  = 64;
   localparam int LINE_SHIFT = $clog2(LINE_BYTES);
   localparam int LINE_IDX_W = $clog2(MEM_LINES);

   localparam int N_AGENTS = 3;   // two units plus the ram
   typedef logic [1:0] agent_id_t;
   localparam agent_id_t UNIT0 = 2'd0;
   localparam agent_id_t UNIT1 = 2'd1;
   localparam agent_id_t MEM   = 2'd2;

   typedef enum logic [1:0] {
      PH_IDLE = 2'd0,   // nobody drives
      PH_ADDR = 2'd1,
      PH_DATA = 2'd2
   } bus_phase_e;

   // all zero when idle, so agents can be ORed together
   typedef struct packed {
      bus_phase_e           phase;
      logic                 rw;     // 1 = write
      logic [ADDR_W-1:0]    addr;   // line byte address, 16-aligned
      agent_id_t            src;
      agent_id_t            dest;
      logic [BEAT_BITS-1:0] data;
   } bus_beat_t;

endpackage

`default_nettype wire

//--- hw/unit_pkg.sv
// controller state encoding
// work-unit request and response structs
`default_nettype none

package unit_pkg;

   typedef enum logic [2:0] {
      ST_IDLE = 3'd0,   // waiting for a request
      ST_BR   = 3'd1,   // bus requested
      ST_MSTR = 3'd2,   // address phase
      ST_WR   = 3'd3,   // write beats
      ST_WAIT = 3'd4,   // read acked, reply not yet seen
      ST_RD   = 3'd5    // read beats
   } ctrl_state_e;

   // held steady by the unit until r
   typedef struct packed {
      logic         en;
      logic         wr;      // 1 = write
      logic [15:0]  addr;
      logic [127:0] wdata;
   } unit_req_t;

   typedef struct packed {
      logic         r;       // one-cycle done pulse
      logic [127:0] rdata;   // last line read
   } unit_rsp_t;

endpackage

`default_nettype wire

//--- hw/bus_ctrl_fsm.sv
// bus controller state machine
// decodes the state into request, drive, capture and size strobes
`default_nettype none

module bus_ctrl_fsm (
   input  logic bus_clk,
   input  logic arst_n,
   input  logic en,          // unit has a request
   input  logic wr,          // request is a write
   input  logic bg,
   input  logic ack,
   input  logic dest_hit,    // data beat addressed to us
   input  logic done,        // current beat is the last of the line
   output logic br,
   output logic drive_addr,
   output logic drive_data,
   output logic capture,
   output logic load_size,
   output logic decr,
   output logic r
);
   import unit_pkg::*;

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   logic        r_q;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         ST_IDLE: begin
            // en is still up in the r cycle for the request just finished
            if (en && !r_q) begin
               state_d = ST_BR;
            end
         end
         ST_BR: begin
            if (bg) begin
               state_d = ST_MSTR;   // address goes out the same cycle
            end
         end
         ST_MSTR: begin
            if (ack) begin
               state_d = wr ? ST_WR : ST_WAIT;
            end
         end
         ST_WR: begin
            if (done) begin
               state_d = ST_IDLE;
            end
         end
         ST_WAIT: begin
            if (dest_hit) begin
               state_d = ST_RD;     // first reply beat
            end
         end
         ST_RD: begin
            if (dest_hit && done) begin
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ST_IDLE;
         r_q     <= 1'b0;
      end else begin
         state_q <= state_d;
         r_q     <= decr && done;   // cycle after the last beat
      end
   end

   // br held from request until the last write beat or the read ack
   assign br         = (state_q == ST_BR) || (state_q == ST_MSTR) || (state_q == ST_WR);
   assign drive_addr = (state_q == ST_MSTR);
   assign drive_data = (state_q == ST_WR);
   assign capture    = dest_hit && ((state_q == ST_WAIT) || (state_q == ST_RD));
   assign load_size  = (state_q == ST_MSTR);   // full line before any beat
   assign decr       = drive_data || capture;
   assign r          = r_q;

endmodule

`default_nettype wire

//--- hw/beat_counter.sv
// transfer size register counting 16 bytes down by 4 per beat
// lane index and last-beat detect
`default_nettype none

module beat_counter (
   input  logic                           bus_clk,
   input  logic                           arst_n,
   input  logic                           load,   // reload a full line
   input  logic                           decr,   // one beat moved
   output logic [bus_pkg::BEAT_IDX_W-1:0] beat,
   output logic                           done
);
   import bus_pkg::*;

   logic [SIZE_W-1:0] size_q;   // bytes left in the line
   logic [SIZE_W-1:0] moved;    // bytes already moved

   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         size_q <= SIZE_W'(LINE_BYTES);
      end else if (decr) begin
         size_q <= size_q - SIZE_W'(BEAT_BYTES);
      end else if (load) begin
         size_q <= SIZE_W'(LINE_BYTES);
      end
   end

   // lane goes up as the size goes down
   assign moved = SIZE_W'(LINE_BYTES) - size_q;
   assign beat  = moved[BEAT_SHIFT +: BEAT_IDX_W];

   // one beat left, so this one empties the line
   assign done  = (size_q == SIZE_W'(BEAT_BYTES));

endmodule

`default_nettype wire

//--- hw/line_buffer.sv
// read line assembly and write beat lane select
// full line register updated on the last read beat
`default_nettype none

module line_buffer (
   input  logic                           bus_clk,
   input  logic                           arst_n,
   input  logic                           capture,     // bus beat is ours
   input  logic [bus_pkg::BEAT_IDX_W-1:0] beat,        // lane of this beat
   input  logic [bus_pkg::BEAT_BITS-1:0]  bus_data,
   input  logic [bus_pkg::LINE_BITS-1:0]  wdata,
   input  logic                           done,        // last beat of the line
   output logic [bus_pkg::BEAT_BITS-1:0]  beat_data,   // outgoing write beat
   output logic [bus_pkg::LINE_BITS-1:0]  rdata
);
   import bus_pkg::*;

   logic [BEATS-1:0][BEAT_BITS-1:0] asm_q;      // lanes collected so far
   logic [BEATS-1:0][BEAT_BITS-1:0] asm_next;
   logic [BEATS-1:0][BEAT_BITS-1:0] wlanes;
   logic [LINE_BITS-1:0]            line_q;     // last complete line

   always_comb begin
      asm_next       = asm_q;
      asm_next[beat] = bus_data;   // beat k lands in lane k
   end

   always_ff @(posedge bus_clk) begin
      if (capture) begin
         asm_q <= asm_next;
      end
   end

   // unit sees a whole line only, held until the next read completes
   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         line_q <= '0;
      end else if (capture && done) begin
         line_q <= asm_next;
      end
   end

   assign rdata = line_q;

   // write side picks wdata[32k +: 32] for beat k
   assign wlanes    = wdata;
   assign beat_data = wlanes[beat];

endmodule

`default_nettype wire

//--- hw/bus_master.sv
// bus controller of one work unit
// control fsm, size counter and line buffer around the bus struct
`default_nettype none

module bus_master #(
   parameter bus_pkg::agent_id_t MY_ID = bus_pkg::UNIT0
) (
   input  logic                bus_clk,
   input  logic                arst_n,
   input  unit_pkg::unit_req_t req,
   input  logic                bg,
   input  logic                ack,
   input  bus_pkg::bus_beat_t  bus_in,
   output unit_pkg::unit_rsp_t rsp,
   output logic                br,
   output bus_pkg::bus_beat_t  bus_out
);
   import bus_pkg::*;

   logic                  dest_hit;
   logic                  done;
   logic                  drive_addr;
   logic                  drive_data;
   logic                  capture;
   logic                  load_size;
   logic                  decr;
   logic                  r;
   logic [BEAT_IDX_W-1:0] beat;
   logic [BEAT_BITS-1:0]  beat_data;
   logic [LINE_BITS-1:0]  rdata;

   // reply beats come back tagged with our id
   assign dest_hit = (bus_in.phase == PH_DATA) && (bus_in.dest == MY_ID);

   bus_ctrl_fsm fsm_u (
      .bus_clk   (bus_clk),
      .arst_n    (arst_n),
      .en        (req.en),
      .wr        (req.wr),
      .bg        (bg),
      .ack       (ack),
      .dest_hit  (dest_hit),
      .done      (done),
      .br        (br),
      .drive_addr(drive_addr),
      .drive_data(drive_data),
      .capture   (capture),
      .load_size (load_size),
      .decr      (decr),
      .r         (r)
   );

   beat_counter cnt_u (
      .bus_clk(bus_clk),
      .arst_n (arst_n),
      .load   (load_size),
      .decr   (decr),
      .beat   (beat),
      .done   (done)
   );

   line_buffer buf_u (
      .bus_clk  (bus_clk),
      .arst_n   (arst_n),
      .capture  (capture),
      .beat     (beat),
      .bus_data (bus_in.data),
      .wdata    (req.wdata),
      .done     (done),
      .beat_data(beat_data),
      .rdata    (rdata)
   );

   always_comb begin
      bus_out = '0;   // zero unless we own the bus
      if (drive_addr || drive_data) begin
         bus_out.phase = drive_addr ? PH_ADDR : PH_DATA;
         bus_out.rw    = req.wr;
         bus_out.addr  = req.addr;
         bus_out.src   = MY_ID;
         bus_out.dest  = MEM;   // units only ever talk to the ram
         bus_out.data  = drive_data ? beat_data : '0;
      end
   end

   assign rsp.r     = r;
   assign rsp.rdata = rdata;

endmodule

`default_nettype wire

//--- hw/bus_arbiter.sv
// bus arbiter with a registered one-hot grant
// round-robin between the units, ram reply served first
`default_nettype none

module bus_arbiter (
   input  logic                         bus_clk,
   input  logic                         arst_n,
   input  logic [bus_pkg::N_AGENTS-1:0] br,   // indexed by agent id
   output logic [bus_pkg::N_AGENTS-1:0] bg
);
   import bus_pkg::*;

   logic [N_AGENTS-1:0] bg_q;
   logic [N_AGENTS-1:0] pick;
   agent_id_t           prio_q;   // unit that wins a tie
   agent_id_t           other;

   assign other = (prio_q == UNIT0) ? UNIT1 : UNIT0;

   // a unit holding the bus waits on a busy ram, so the ram reply goes first
   always_comb begin
      pick = '0;
      if (br[MEM]) begin
         pick[MEM] = 1'b1;
      end else if (br[prio_q]) begin
         pick[prio_q] = 1'b1;
      end else if (br[other]) begin
         pick[other] = 1'b1;
      end
   end

   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         bg_q   <= '0;
         prio_q <= UNIT0;
      end else if (bg_q == '0) begin
         bg_q <= pick;   // new grant only from a free bus
         if (pick[UNIT0]) begin
            prio_q <= UNIT1;
         end else if (pick[UNIT1]) begin
            prio_q <= UNIT0;
         end else if (pick[MEM]) begin
            prio_q <= UNIT0;   // rotation wraps from the ram back to unit 0
         end
      end else if ((bg_q & br) == '0) begin
         bg_q <= '0;     // owner let go of br
      end
   end

   assign bg = bg_q;

endmodule

`default_nettype wire

//--- hw/mem_responder.sv
// ram-side bus agent with the line array
// acks one request at a time, absorbs write beats, returns read lines
`default_nettype none

module mem_responder (
   input  logic               bus_clk,
   input  logic               arst_n,
   input  bus_pkg::bus_beat_t bus_in,
   input  logic               bg,
   output logic               ack,
   output logic               br,
   output bus_pkg::bus_beat_t bus_out
);
   import bus_pkg::*;

   typedef enum logic [1:0] {
      R_IDLE   = 2'd0,   // free to take a request
      R_WBEATS = 2'd1,   // absorbing write beats
      R_RREQ   = 2'd2,   // read line ready, asking for the bus
      R_REPLY  = 2'd3    // driving the read beats
   } resp_state_e;

   resp_state_e                     state_q;
   logic                            ack_q;
   logic [BEAT_IDX_W-1:0]           lane_q;
   logic [ADDR_W-1:0]               addr_q;
   agent_id_t                       src_q;      // requester, reply goes here
   logic [BEATS-1:0][BEAT_BITS-1:0] wline_q;
   logic [BEATS-1:0][BEAT_BITS-1:0] wline_next;
   logic [BEATS-1:0][BEAT_BITS-1:0] rline_q;
   logic [LINE_BITS-1:0]            mem_q [MEM_LINES];
   logic [LINE_IDX_W-1:0]           req_idx;
   logic [LINE_IDX_W-1:0]           wr_idx;
   logic                            req_hit;
   logic                            wbeat_hit;
   logic                            last_lane;

   // busy states ignore the address phase, which withholds ack
   assign req_hit   = (state_q == R_IDLE) && (bus_in.phase == PH_ADDR) && (bus_in.dest == MEM);
   assign wbeat_hit = (state_q == R_WBEATS) && (bus_in.phase == PH_DATA)
                      && (bus_in.dest == MEM);
   assign last_lane = (lane_q == BEAT_IDX_W'(BEATS - 1));
   assign req_idx   = bus_in.addr[LINE_SHIFT +: LINE_IDX_W];
   assign wr_idx    = addr_q[LINE_SHIFT +: LINE_IDX_W];

   always_comb begin
      wline_next         = wline_q;
      wline_next[lane_q] = bus_in.data;
   end

   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= R_IDLE;
         ack_q   <= 1'b0;
         lane_q  <= '0;
      end else begin
         ack_q <= req_hit;   // one-cycle pulse
         unique case (state_q)
            R_IDLE: begin
               if (req_hit) begin
                  state_q <= bus_in.rw ? R_WBEATS : R_RREQ;
                  lane_q  <= '0;
               end
            end
            R_WBEATS: begin
               if (wbeat_hit) begin
                  lane_q <= lane_q + 1'b1;
                  if (last_lane) state_q <= R_IDLE;
               end
            end
            R_RREQ: begin
               if (bg) state_q <= R_REPLY;
            end
            R_REPLY: begin
               lane_q <= lane_q + 1'b1;   // one beat per cycle
               if (last_lane) state_q <= R_IDLE;
            end
            default: state_q <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge bus_clk) begin
      if (req_hit) begin
         addr_q  <= bus_in.addr;
         src_q   <= bus_in.src;
         rline_q <= mem_q[req_idx];   // read line fetched at request time
      end
      if (wbeat_hit) wline_q <= wline_next;
   end

   // line written at the end of the fourth beat
   always_ff @(posedge bus_clk) begin
      if (wbeat_hit && last_lane) mem_q[wr_idx] <= wline_next;
   end

   always_comb begin
      bus_out = '0;
      if (state_q == R_REPLY) begin
         bus_out.phase = PH_DATA;
         bus_out.rw    = 1'b0;
         bus_out.addr  = addr_q;
         bus_out.src   = MEM;
         bus_out.dest  = src_q;
         bus_out.data  = rline_q[lane_q];
      end
   end

   assign br  = (state_q == R_RREQ) || (state_q == R_REPLY);
   assign ack = ack_q;

endmodule

`default_nettype wire

//--- hw/mem_bus_top.sv
// memory bus top level with two unit controllers, arbiter and ram
// bus is the OR of the agent structs
`default_nettype none

module mem_bus_top (
   input  logic                bus_clk,
   input  logic                arst_n,
   input  unit_pkg::unit_req_t req0,
   input  unit_pkg::unit_req_t req1,
   output unit_pkg::unit_rsp_t rsp0,
   output unit_pkg::unit_rsp_t rsp1
);
   import bus_pkg::*;

   logic [N_AGENTS-1:0] br;
   logic [N_AGENTS-1:0] bg;
   logic                ack;       // seen only by the master in its address phase
   bus_beat_t           bus_m0;
   bus_beat_t           bus_m1;
   bus_beat_t           bus_ram;
   bus_beat_t           bus;

   bus_master #(.MY_ID(UNIT0)) master0_u (
      .bus_clk(bus_clk),
      .arst_n (arst_n),
      .req    (req0),
      .bg     (bg[UNIT0]),
      .ack    (ack),
      .bus_in (bus),
      .rsp    (rsp0),
      .br     (br[UNIT0]),
      .bus_out(bus_m0)
   );

   bus_master #(.MY_ID(UNIT1)) master1_u (
      .bus_clk(bus_clk),
      .arst_n (arst_n),
      .req    (req1),
      .bg     (bg[UNIT1]),
      .ack    (ack),
      .bus_in (bus),
      .rsp    (rsp1),
      .br     (br[UNIT1]),
      .bus_out(bus_m1)
   );

   bus_arbiter arbiter_u (
      .bus_clk(bus_clk),
      .arst_n (arst_n),
      .br     (br),
      .bg     (bg)
   );

   mem_responder ram_u (
      .bus_clk(bus_clk),
      .arst_n (arst_n),
      .bus_in (bus),
      .bg     (bg[MEM]),
      .ack    (ack),
      .br     (br[MEM]),
      .bus_out(bus_ram)
   );

   // only the granted agent drives nonzero
   assign bus = bus_beat_t'(bus_m0 | bus_m1 | bus_ram);

endmodule

`default_nettype wire

//--- test/tb_mem_bus.sv
// testbench for the two-unit memory bus
// lfsr stimulus, reference ram model, response compare process and report
`default_nettype none

module tb_mem_bus;
   timeunit 1ns;
   timeprecision 100ps;

   import bus_pkg::*;
   import unit_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 8;
   localparam int WAIT_LIMIT   = 300;   // cycles per request, arbitration included
   localparam int N_RANDOM     = 50;

   typedef struct packed {
      logic                 is_read;
      logic [LINE_BITS-1:0] line;    // expected rdata for a read
   } expect_t;

   typedef struct packed {
      logic                 wr;
      logic [ADDR_W-1:0]    addr;
      logic [LINE_BITS-1:0] wdata;
   } op_t;

   logic      bus_clk;
   logic      arst_n;
   unit_req_t req0;
   unit_req_t req1;
   unit_rsp_t rsp0;
   unit_rsp_t rsp1;

   logic [31:0]          lfsr_q;
   logic [LINE_BITS-1:0] ref_mem [int];   // reference ram, keyed by line index
   expect_t              exp0_q [$];      // outstanding requests per unit
   expect_t              exp1_q [$];
   op_t                  ops0_q [$];
   op_t                  ops1_q [$];
   int                   value_errs;
   int                   other_errs;
   int                   reads_checked;

   mem_bus_top dut_i (
      .bus_clk(bus_clk),
      .arst_n (arst_n),
      .req0   (req0),
      .req1   (req1),
      .rsp0   (rsp0),
      .rsp1   (rsp1)
   );

   initial begin
      bus_clk = 1'b0;
      forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
   end

   // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic logic [LINE_BITS-1:0] rand_bits(input int n);
      logic [LINE_BITS-1:0] v;
      int                   i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);      // one step per bit
         v      = {v[LINE_BITS-2:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // upper bits are random and alias onto the same line
   function automatic logic [ADDR_W-1:0] line_addr(input logic [5:0] idx);
      logic [5:0] upper;
      upper = 6'(rand_bits(6));
      return {upper, idx, 4'h0};
   endfunction

   // ram is indexed by addr[9:4]
   function automatic logic [LINE_BITS-1:0] ref_read(input logic [ADDR_W-1:0] addr);
      if (ref_mem.exists(int'(addr[9:4]))) begin
         return ref_mem[int'(addr[9:4])];
      end
      return '0;
   endfunction

   function automatic void ref_write(input logic [ADDR_W-1:0] addr,
                                     input logic [LINE_BITS-1:0] line);
      ref_mem[int'(addr[9:4])] = line;
   endfunction

   task automatic check_idle(input unit_rsp_t got, input int unit);
      if (got.r !== 1'b0 || got.rdata !== '0) begin
         value_errs++;
         $display("Fail at %0t: unit %0d not idle, r=%b rdata=%h",
                  $time, unit, got.r, got.rdata);
      end
   endtask

   task automatic check_line(input unit_rsp_t got, input logic [LINE_BITS-1:0] exp,
                             input int unit);
      if (got.rdata !== exp) begin
         value_errs++;
         $display("Fail at %0t: unit %0d read %h, expected %h", $time, unit, got.rdata, exp);
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d value, %0d other; %0d reads checked",
               value_errs, other_errs, reads_checked);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   endtask

   // oldest outstanding request of the unit ends with this r
   task automatic retire(input int unit, input unit_rsp_t got);
      expect_t e;
      if ((unit == 0 && exp0_q.size() == 0) || (unit == 1 && exp1_q.size() == 0)) begin
         other_errs++;
         $display("unit %0d pulsed r at %0t with no request outstanding", unit, $time);
      end else begin
         if (unit == 0) begin
            e = exp0_q.pop_front();
         end else begin
            e = exp1_q.pop_front();
         end
         if (e.is_read) begin
            check_line(got, e.line, unit);
            reads_checked++;
         end
      end
   endtask

   // compare process, r is registered so the falling edge sees it settled
   always @(negedge bus_clk) begin
      if (arst_n) begin
         if (rsp0.r) retire(0, rsp0);
         if (rsp1.r) retire(1, rsp1);
      end
   end

   // drive one request at a falling edge and hold it until r
   task automatic issue(input int unit, input logic wr, input logic [ADDR_W-1:0] addr,
                        input logic [LINE_BITS-1:0] wdata, output time done_at);
      unit_req_t q;
      expect_t   e;
      int        cycles;
      logic      seen;
      q.en      = 1'b1;
      q.wr      = wr;
      q.addr    = addr;
      q.wdata   = wdata;
      e.is_read = !wr;
      if (wr) begin
         ref_write(addr, wdata);
         e.line = wdata;
      end else begin
         e.line = ref_read(addr);
      end
      if (unit == 0) begin
         req0 = q;
         exp0_q.push_back(e);
      end else begin
         req1 = q;
         exp1_q.push_back(e);
      end
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < WAIT_LIMIT) begin
         @(negedge bus_clk);
         seen = (unit == 0) ? rsp0.r : rsp1.r;
         cycles++;
      end
      if (!seen) begin
         other_errs++;
         $display("unit %0d timed out after %0d cycles waiting for r", unit, cycles);
         finish_run();
      end else begin
         done_at = $time;
         if (unit == 0) begin
            req0.en = 1'b0;   // request done
         end else begin
            req1.en = 1'b0;
         end
      end
   endtask

   // unit u keeps to lines whose index parity is u, so the units never race
   task automatic plan_random_ops();
      int         pool0 [$];
      int         pool1 [$];
      op_t        op;
      int         n;
      int         pick;
      logic       unit;
      logic [5:0] idx;
      for (n = 0; n < N_RANDOM; n++) begin
         unit  = 1'(rand_bits(1));
         op.wr = 1'(rand_bits(1));
         if ((!unit && pool0.size() == 0) || (unit && pool1.size() == 0)) begin
            op.wr = 1'b1;   // no line of ours written yet
         end
         if (op.wr) begin
            idx      = {5'(rand_bits(5)), unit};
            op.wdata = rand_bits(LINE_BITS);
            if (unit) begin
               pool1.push_back(int'(idx));
            end else begin
               pool0.push_back(int'(idx));
            end
         end else begin
            pick     = int'(rand_bits(5));
            op.wdata = '0;
            if (unit) begin
               idx = 6'(pool1[pick % pool1.size()]);
            end else begin
               idx = 6'(pool0[pick % pool0.size()]);
            end
         end
         op.addr = line_addr(idx);
         if (unit) begin
            ops1_q.push_back(op);
         end else begin
            ops0_q.push_back(op);
         end
      end
   endtask

   task automatic run_ops(input int unit);
      op_t op;
      time t;
      while ((unit == 0 && ops0_q.size() != 0) || (unit == 1 && ops1_q.size() != 0)) begin
         if (unit == 0) begin
            op = ops0_q.pop_front();
         end else begin
            op = ops1_q.pop_front();
         end
         issue(unit, op.wr, op.addr, op.wdata, t);
      end
   endtask

   initial begin
      logic [ADDR_W-1:0]    a0;
      logic [ADDR_W-1:0]    a1;
      logic [LINE_BITS-1:0] d0;
      logic [LINE_BITS-1:0] d1;
      time                  t0;
      time                  t1;
      lfsr_q        = 32'h3a3f;
      arst_n        = 1'b0;
      req0          = '0;
      req1          = '0;
      value_errs    = 0;
      other_errs    = 0;
      reads_checked = 0;

      // responses stay quiet in reset and just after
      repeat (RESET_CYCLES) begin
         @(negedge bus_clk);
         check_idle(rsp0, 0);
         check_idle(rsp1, 1);
      end
      arst_n = 1'b1;
      repeat (4) begin
         @(negedge bus_clk);
         check_idle(rsp0, 0);
         check_idle(rsp1, 1);
      end

      // unit 0 write then read back, lane order must hold
      a0 = line_addr(6'(rand_bits(6)));
      d0 = rand_bits(LINE_BITS);
      issue(0, 1'b1, a0, d0, t0);
      issue(0, 1'b0, a0, '0, t0);

      // written by unit 1, read by unit 0
      a1 = line_addr(6'(rand_bits(6)));
      d1 = rand_bits(LINE_BITS);
      issue(1, 1'b1, a1, d1, t1);
      issue(0, 1'b0, a1, '0, t0);

      // simultaneous writes, unit 0 wins the first grant
      a0 = line_addr({5'(rand_bits(5)), 1'b0});
      a1 = line_addr({5'(rand_bits(5)), 1'b1});
      d0 = rand_bits(LINE_BITS);
      d1 = rand_bits(LINE_BITS);
      @(negedge bus_clk);   // unit 0 past its r cycle, both fsms see en together
      fork
         issue(0, 1'b1, a0, d0, t0);
         issue(1, 1'b1, a1, d1, t1);
      join
      if (t0 >= t1) begin
         value_errs++;
         $display("Fail at %0t: unit 1 done at %0t, not after unit 0 at %0t", $time, t1, t0);
      end
      fork
         issue(0, 1'b0, a0, '0, t0);
         issue(1, 1'b0, a1, '0, t1);
      join

      // random mix from both units at once
      plan_random_ops();
      fork
         run_ops(0);
         run_ops(1);
      join

      @(negedge bus_clk);   // let the compare process retire the last r
      if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
         other_errs++;
         $display("requests left without r: unit 0 %0d, unit 1 %0d",
                  exp0_q.size(), exp1_q.size());
      end
      finish_run();
   end

endmodule

`default_nettype wire

//--- mem_bus.f
hw/bus_pkg.sv
hw/unit_pkg.sv
hw/bus_ctrl_fsm.sv
hw/beat_counter.sv
hw/line_buffer.sv
hw/bus_master.sv
hw/bus_arbiter.sv
hw/mem_responder.sv
hw/mem_bus_top.sv
test/tb_mem_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the mem_bus testbench with Verilator and run it into sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -j 0 \
   -f mem_bus.f --top-module tb_mem_bus -o tb_mem_bus

./obj_dir/tb_mem_bus | tee sim.log

if grep -q "Test FAILED" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation passed"
